//--- Bender.yml
package:
  name: cpu16_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - core/cpu_control.sv
      - core/cpu_regfile.sv
      - core/cpu_alu.sv
      - core/cpu_writeback.sv
      - lsu/cpu_lsu.sv
      - verilog/cpu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_cpu_mem.sv
      - sim/cpu_asserts.sv
      - sim/tb_cpu_top.sv

//--- build.f
+incdir+common
common/cpu_pkg.sv
core/cpu_control.sv
core/cpu_regfile.sv
core/cpu_alu.sv
core/cpu_writeback.sv
lsu/cpu_lsu.sv
verilog/cpu_top.sv
sim/tb_cpu_mem.sv
sim/cpu_asserts.sv
sim/tb_cpu_top.sv

//--- common/cpu_defines.svh
/*
 * Core-wide width and address macros: data word, register index,
 * program counter, link register and reset vector.
 */

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define CPU_DATA_BITS 16	// One machine word.
`define CPU_REG_SEL_BITS 4	// Sixteen registers.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program flow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// The PC counts instruction words, not bytes.
`define CPU_PC_BITS 8
`define CPU_LINK_REG 4'd15	// Receives pc + 1 on branch with link.
`define CPU_RESET_PC 8'h00

`endif

//--- common/cpu_pkg.sv
/*
 * Core types: opcode enum, the two instruction word views,
 * the ALU flag struct and the AXI4-Lite request/response bundles.
 */

`include "cpu_defines.svh"

package cpu_pkg;

	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_LDI  = 4'h5,
		OP_ADDI = 4'h6,
		OP_LD   = 4'h7,
		OP_ST   = 4'h8,
		OP_LDB  = 4'h9,
		OP_LDBS = 4'hA,
		OP_IN   = 4'hB,
		OP_OUT  = 4'hC,
		OP_MOVC = 4'hD,
		OP_BR   = 4'hE,
		OP_HALT = 4'hF
	} cpu_opcode_t;

	// Register form. For MOVC the rb field carries the condition code.
	typedef struct packed {
		cpu_opcode_t opcode;
		logic [`CPU_REG_SEL_BITS-1:0] rd;
		logic [`CPU_REG_SEL_BITS-1:0] ra;
		logic [`CPU_REG_SEL_BITS-1:0] rb;
	} cpu_rr_t;

	typedef struct packed {
		cpu_opcode_t opcode;
		logic [`CPU_REG_SEL_BITS-1:0] rd;	// Nonzero on BR means link.
		logic [7:0] imm8;
	} cpu_ri_t;

	typedef union packed {
		cpu_rr_t rr;
		cpu_ri_t ri;
	} cpu_instr_u;

	typedef struct packed {
		logic z;
		logic s;
		logic c;	// Borrow after SUB.
		logic v;
	} cpu_flags_t;

	// Master side of the data bus.
	typedef struct packed {
		logic awvalid;
		logic [31:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		logic [31:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
	} axil_rsp_t;

endpackage

//--- core/cpu_alu.sv
/*
 * ALU: arithmetic and logic operations with a registered result
 * and the Z/S/C/V flag register.
 */

`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_alu (
	input logic clk,
	input logic reset,
	input logic exec_en,
	input cpu_pkg::cpu_instr_u instr,
	input logic [`CPU_DATA_BITS-1:0] op_a,
	input logic [`CPU_DATA_BITS-1:0] op_b,
	output logic [`CPU_DATA_BITS-1:0] result,
	output cpu_pkg::cpu_flags_t flags
);

	localparam int W = `CPU_DATA_BITS;

	logic [W-1:0] res_d;
	logic [W:0] wide;	// One extra bit for carry or borrow.
	logic [W-1:0] imm_ext;
	logic carry_d;
	logic ovf_d;
	logic set_flags;

	assign imm_ext = W'(signed'(instr.ri.imm8));

	always_comb begin
		wide = '0;
		res_d = op_a;	// MOVC and everything else pass op_a.
		carry_d = 1'b0;
		ovf_d = 1'b0;
		set_flags = 1'b0;
		case (instr.rr.opcode)
			cpu_pkg::OP_ADD: begin
				wide = {1'b0, op_a} + {1'b0, op_b};
				res_d = wide[W-1:0];
				carry_d = wide[W];
				ovf_d = (op_a[W-1] == op_b[W-1]) && (res_d[W-1] != op_a[W-1]);
				set_flags = 1'b1;
			end
			cpu_pkg::OP_SUB: begin
				wide = {1'b0, op_a} - {1'b0, op_b};
				res_d = wide[W-1:0];
				carry_d = wide[W];	// Borrow.
				ovf_d = (op_a[W-1] != op_b[W-1]) && (res_d[W-1] != op_a[W-1]);
				set_flags = 1'b1;
			end
			cpu_pkg::OP_AND: begin
				res_d = op_a & op_b;
				set_flags = 1'b1;
			end
			cpu_pkg::OP_OR: begin
				res_d = op_a | op_b;
				set_flags = 1'b1;
			end
			cpu_pkg::OP_XOR: begin
				res_d = op_a ^ op_b;
				set_flags = 1'b1;
			end
			cpu_pkg::OP_LDI: res_d = W'(instr.ri.imm8);	// Zero extended, flags kept.
			cpu_pkg::OP_ADDI: begin
				wide = {1'b0, op_a} + {1'b0, imm_ext};
				res_d = wide[W-1:0];
				carry_d = wide[W];
				ovf_d = (op_a[W-1] == imm_ext[W-1]) && (res_d[W-1] != op_a[W-1]);
				set_flags = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			flags <= '0;
		end else if (exec_en) begin
			result <= res_d;
			if (set_flags) begin
				flags.z <= (res_d == '0);
				flags.s <= res_d[W-1];
				flags.c <= carry_d;
				flags.v <= ovf_d;
			end
		end
	end

endmodule

//--- core/cpu_control.sv
/*
 * Sequencer FSM: program counter, instruction register and the
 * per-phase enables for ALU, load/store unit and register writeback.
 */

`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_control (
	input logic clk,
	input logic reset,
	input logic [15:0] instr_data,
	input logic mem_done,
	output logic [7:0] fetch_addr,
	output cpu_pkg::cpu_instr_u instr,
	output logic [7:0] pc_next,
	output logic exec_en,
	output logic mem_start,
	output logic wb_en,
	output logic port_strobe,
	output logic halted
);

	localparam int PC_W = `CPU_PC_BITS;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXEC,
		ST_MEM,
		ST_WB,
		ST_HALTED
	} state_t;

	state_t state;
	logic [PC_W-1:0] pc;
	logic [PC_W-1:0] br_target;
	logic needs_mem;
	cpu_pkg::cpu_opcode_t opcode;

	assign opcode = instr.rr.opcode;

	// Only the memory class goes through the MEM phase.
	assign needs_mem = (opcode == cpu_pkg::OP_LD) || (opcode == cpu_pkg::OP_ST) ||
		(opcode == cpu_pkg::OP_LDB) || (opcode == cpu_pkg::OP_LDBS);

	// Relative to the following instruction, imm8 sign extended.
	assign br_target = pc_next + PC_W'(signed'(instr.ri.imm8));

	assign fetch_addr = pc;
	assign pc_next = pc + 1'b1;

	assign exec_en = (state == ST_EXEC);
	assign mem_start = (state == ST_EXEC) && needs_mem;
	assign wb_en = (state == ST_WB);
	assign port_strobe = (state == ST_WB) && (opcode == cpu_pkg::OP_OUT);
	assign halted = (state == ST_HALTED);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_FETCH;
			pc <= `CPU_RESET_PC;
			instr <= '0;
		end else begin
			case (state)
				ST_FETCH: begin
					state <= ST_DECODE;	// ROM answers one cycle later.
				end
				ST_DECODE: begin
					instr <= instr_data;
					state <= ST_EXEC;
				end
				ST_EXEC: begin
					state <= needs_mem ? ST_MEM : ST_WB;
				end
				ST_MEM: begin
					if (mem_done)
						state <= ST_WB;	// Stays here for as long as the bus stalls.
				end
				ST_WB: begin
					if (opcode == cpu_pkg::OP_BR)
						pc <= br_target;
					else
						pc <= pc_next;
					// HALT still passes through WB, where it writes r0 only.
					state <= (opcode == cpu_pkg::OP_HALT) ? ST_HALTED : ST_FETCH;
				end
				ST_HALTED: begin
					state <= ST_HALTED;	// Left only through reset.
				end
				default: begin
					state <= ST_FETCH;
				end
			endcase
		end
	end

endmodule

//--- core/cpu_regfile.sv
/*
 * Register file: two asynchronous read ports, one synchronous write port.
 */

`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_regfile (
	input logic clk,
	input logic reset,
	input logic [`CPU_REG_SEL_BITS-1:0] rd_sel_a,
	input logic [`CPU_REG_SEL_BITS-1:0] rd_sel_b,
	output logic [`CPU_DATA_BITS-1:0] rd_data_a,
	output logic [`CPU_DATA_BITS-1:0] rd_data_b,
	input logic wr_en,
	input logic [`CPU_REG_SEL_BITS-1:0] wr_sel,
	input logic [`CPU_DATA_BITS-1:0] wr_data
);

	localparam int NUM_REGS = 1 << `CPU_REG_SEL_BITS;

	logic [`CPU_DATA_BITS-1:0] regs [NUM_REGS];

	// A write aimed at r0 is how an instruction throws its result away.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_sel != '0)) begin
			regs[wr_sel] <= wr_data;
		end
	end

	assign rd_data_a = (rd_sel_a == '0) ? '0 : regs[rd_sel_a];
	assign rd_data_b = (rd_sel_b == '0) ? '0 : regs[rd_sel_b];

endmodule

//--- core/cpu_writeback.sv
/*
 * Writeback select: destination register and write data for each
 * instruction class, with byte extraction and extension for byte loads.
 */

`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_writeback (
	input cpu_pkg::cpu_instr_u instr,
	input logic [`CPU_DATA_BITS-1:0] alu_result,
	input logic [`CPU_DATA_BITS-1:0] mem_data,
	input logic [1:0] mem_byte_sel,
	input logic [`CPU_DATA_BITS-1:0] port_in,
	input logic [`CPU_PC_BITS-1:0] pc_link,
	input cpu_pkg::cpu_flags_t flags,
	output logic [`CPU_REG_SEL_BITS-1:0] wr_sel,
	output logic [`CPU_DATA_BITS-1:0] wr_data
);

	logic [7:0] byte_val;

	// MOVC condition codes live in the rb field.
	function automatic logic cond_holds(input logic [3:0] cond, input cpu_pkg::cpu_flags_t f);
		case (cond)
			4'd0: cond_holds = 1'b1;
			4'd1: cond_holds = f.z;
			4'd2: cond_holds = !f.z;
			4'd3: cond_holds = f.c;
			4'd4: cond_holds = f.s;
			default: cond_holds = 1'b0;
		endcase
	endfunction

	// mem_data is already the addressed halfword, so the low select bit picks the byte.
	always_comb begin
		case (mem_byte_sel)
			2'b00, 2'b10: byte_val = mem_data[7:0];
			2'b01, 2'b11: byte_val = mem_data[15:8];
			default: byte_val = mem_data[7:0];
		endcase
	end

	always_comb begin
		wr_sel = '0;	// r0 soaks up anything that writes nothing.
		wr_data = '0;
		case (instr.rr.opcode)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
			cpu_pkg::OP_XOR, cpu_pkg::OP_LDI, cpu_pkg::OP_ADDI: begin
				wr_sel = instr.rr.rd;
				wr_data = alu_result;
			end
			cpu_pkg::OP_LD: begin
				wr_sel = instr.rr.rd;
				wr_data = mem_data;
			end
			cpu_pkg::OP_LDB: begin
				wr_sel = instr.rr.rd;
				wr_data = {8'h00, byte_val};
			end
			cpu_pkg::OP_LDBS: begin
				wr_sel = instr.rr.rd;
				wr_data = {{8{byte_val[7]}}, byte_val};
			end
			cpu_pkg::OP_IN: begin
				wr_sel = instr.rr.rd;
				wr_data = port_in;
			end
			cpu_pkg::OP_MOVC: begin
				if (cond_holds(instr.rr.rb, flags)) begin
					wr_sel = instr.rr.rd;
					wr_data = alu_result;	// ALU passed ra through.
				end
			end
			cpu_pkg::OP_BR: begin
				if (instr.ri.rd != '0) begin
					wr_sel = `CPU_LINK_REG;
					wr_data = `CPU_DATA_BITS'(pc_link);
				end
			end
			default: ;
		endcase
	end

endmodule

//--- lsu/cpu_lsu.sv
/*
 * Load/store unit: AXI4-Lite master for halfword and byte loads and
 * halfword stores, with 16-bit lane placement on the 32-bit bus.
 */

`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_lsu (
	input logic clk,
	input logic reset,
	input logic mem_start,
	input cpu_pkg::cpu_instr_u instr,
	input logic [15:0] addr,
	input logic [`CPU_DATA_BITS-1:0] store_data,
	output cpu_pkg::axil_req_t axi_req,
	input cpu_pkg::axil_rsp_t axi_rsp,
	output logic [`CPU_DATA_BITS-1:0] mem_data,
	output logic [1:0] mem_byte_sel,
	output logic mem_done
);

	// Channel state.
	logic aw_valid;
	logic w_valid;
	logic b_ready;
	logic ar_valid;
	logic r_ready;

	// Request payload, held while the handshakes run.
	logic [31:0] addr_q;
	logic [31:0] wdata_q;
	logic [3:0] wstrb_q;

	logic aw_left;
	logic w_left;

	assign aw_left = aw_valid && !axi_rsp.awready;	// Still waiting after this cycle.
	assign w_left = w_valid && !axi_rsp.wready;

	assign mem_done = (b_ready && axi_rsp.bvalid) || (r_ready && axi_rsp.rvalid);

	always_comb begin
		axi_req = '0;
		axi_req.awvalid = aw_valid;
		axi_req.awaddr = addr_q;
		axi_req.wvalid = w_valid;
		axi_req.wdata = wdata_q;
		axi_req.wstrb = wstrb_q;
		axi_req.bready = b_ready;
		axi_req.arvalid = ar_valid;
		axi_req.araddr = addr_q;
		axi_req.rready = r_ready;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request payload
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (mem_start) begin
			addr_q <= {16'h0000, addr[15:2], 2'b00};	// Bus address is word aligned.
			mem_byte_sel <= addr[1:0];
			if (addr[1]) begin
				wdata_q <= {store_data, 16'h0000};
				wstrb_q <= 4'b1100;
			end else begin
				wdata_q <= {16'h0000, store_data};
				wstrb_q <= 4'b0011;
			end
		end
		// The upper lane is chosen by address bit 1, kept in mem_byte_sel.
		if (r_ready && axi_rsp.rvalid)
			mem_data <= mem_byte_sel[1] ? axi_rsp.rdata[31:16] : axi_rsp.rdata[15:0];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			aw_valid <= 1'b0;
			w_valid <= 1'b0;
			b_ready <= 1'b0;
			ar_valid <= 1'b0;
			r_ready <= 1'b0;
		end else if (mem_start) begin
			if (instr.rr.opcode == cpu_pkg::OP_ST) begin
				aw_valid <= 1'b1;
				w_valid <= 1'b1;
			end else begin
				ar_valid <= 1'b1;	// LD, LDB and LDBS all read a full word.
			end
		end else begin
			aw_valid <= aw_left;
			w_valid <= w_left;
			// Response phase opens once both address and data have been taken.
			if ((aw_valid || w_valid) && !aw_left && !w_left)
				b_ready <= 1'b1;
			else if (b_ready && axi_rsp.bvalid)
				b_ready <= 1'b0;

			if (ar_valid && axi_rsp.arready) begin
				ar_valid <= 1'b0;
				r_ready <= 1'b1;
			end else if (r_ready && axi_rsp.rvalid) begin
				r_ready <= 1'b0;
			end
		end
	end

endmodule

//--- sim/cpu_asserts.sv
/*
 * Bus and halt properties of the core, bound to cpu_top.
 */

`timescale 1ns/1ps

module cpu_asserts (
	input logic clk,
	input logic reset,
	input cpu_pkg::axil_req_t dm_req,
	input cpu_pkg::axil_rsp_t dm_rsp,
	input logic halted
);

	// A valid stays up, with a stable payload, until its ready.
	aw_hold: assert property (@(posedge clk) disable iff (reset)
		dm_req.awvalid && !dm_rsp.awready |=> dm_req.awvalid && $stable(dm_req.awaddr))
		else $error("awvalid dropped or awaddr changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (reset)
		dm_req.wvalid && !dm_rsp.wready |=>
		dm_req.wvalid && $stable(dm_req.wdata) && $stable(dm_req.wstrb))
		else $error("wvalid dropped or write data changed before wready");

	ar_hold: assert property (@(posedge clk) disable iff (reset)
		dm_req.arvalid && !dm_rsp.arready |=> dm_req.arvalid && $stable(dm_req.araddr))
		else $error("arvalid dropped or araddr changed before arready");

	no_mixed_request: assert property (@(posedge clk) disable iff (reset)
		!(dm_req.arvalid && dm_req.awvalid))
		else $error("read and write addresses requested together");

	halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
		else $error("halted dropped without reset");

endmodule

bind cpu_top cpu_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.dm_req(dm_req),
	.dm_rsp(dm_rsp),
	.halted(halted)
);

//--- sim/tb_cpu_mem.sv
/*
 * Behavioral memories: one-cycle instruction ROM and an AXI4-Lite
 * slave data memory with optional random stalls and a wstrb log.
 */

`timescale 1ns/1ps

`include "cpu_defines.svh"

module tb_cpu_mem (
	input logic clk,
	input logic reset,
	input logic stall_en,
	input logic [`CPU_PC_BITS-1:0] imem_addr,
	output logic [15:0] imem_data,
	input cpu_pkg::axil_req_t dm_req,
	output cpu_pkg::axil_rsp_t dm_rsp
);

	logic [15:0] rom [256];
	logic [31:0] dmem [64];	// Indexed by byte address bits 7..2.
	logic [3:0] wstrb_log [$];

	logic [3:0] rnd;	// Per-cycle ready and valid enables.
	logic aw_got;
	logic w_got;
	logic ar_got;
	logic bvalid;
	logic rvalid;
	logic [31:0] waddr;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic [31:0] raddr;
	logic [31:0] rdata;

	always @(posedge clk) begin
		imem_data <= rom[imem_addr];
	end

	// One seeded random stream drives all the stalls.
	initial begin
		void'($urandom(1));
		forever begin
			@(posedge clk);
			rnd <= stall_en ? 4'($urandom) : 4'hF;
		end
	end

	always_comb begin
		dm_rsp = '0;
		dm_rsp.awready = !aw_got && rnd[0];
		dm_rsp.wready = !w_got && rnd[1];
		dm_rsp.arready = !ar_got && rnd[2];
		dm_rsp.bvalid = bvalid;
		dm_rsp.rvalid = rvalid;
		dm_rsp.rdata = rdata;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Slave channel handling
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		if (reset) begin
			aw_got <= 1'b0;
			w_got <= 1'b0;
			ar_got <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			wstrb_log.delete();
		end else begin
			if (dm_req.awvalid && dm_rsp.awready) begin
				aw_got <= 1'b1;
				waddr <= dm_req.awaddr;
			end
			if (dm_req.wvalid && dm_rsp.wready) begin
				w_got <= 1'b1;
				wdata <= dm_req.wdata;
				wstrb <= dm_req.wstrb;
			end
			// The write lands once, when the response is raised.
			if (aw_got && w_got && !bvalid && rnd[3]) begin
				for (int b = 0; b < 4; b++)
					if (wstrb[b])
						dmem[waddr[7:2]][8*b +: 8] <= wdata[8*b +: 8];
				wstrb_log.push_back(wstrb);
				bvalid <= 1'b1;
			end
			if (bvalid && dm_req.bready) begin
				bvalid <= 1'b0;
				aw_got <= 1'b0;
				w_got <= 1'b0;
			end
			if (dm_req.arvalid && dm_rsp.arready) begin
				ar_got <= 1'b1;
				raddr <= dm_req.araddr;
			end
			if (ar_got && !rvalid && rnd[3]) begin
				rvalid <= 1'b1;
				rdata <= dmem[raddr[7:2]];
			end
			if (rvalid && dm_req.rready) begin
				rvalid <= 1'b0;
				ar_got <= 1'b0;
			end
		end
	end

endmodule

//--- sim/tb_cpu_top.sv
/*
 * Testbench for the core: clock, reset, program building, directed
 * tests for ALU, memory, byte loads, MOVC, branches and halt, and the report.
 */

`timescale 1ns/1ps

`include "cpu_defines.svh"

module tb_cpu_top;

	localparam int RUN_LIMIT = 20000;	// Cycles allowed per program.

	logic clk;
	logic reset;
	logic stall_en;
	logic [15:0] port_in;
	logic [`CPU_PC_BITS-1:0] imem_addr;
	logic [15:0] imem_data;
	cpu_pkg::axil_req_t dm_req;
	cpu_pkg::axil_rsp_t dm_rsp;
	logic [15:0] port_out;
	logic port_strobe;
	logic halted;

	logic [15:0] prog [$];
	logic [15:0] outs [$];
	logic [15:0] exp_q [$];
	int run_cycles;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	cpu_top u_cpu_top (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dm_req(dm_req),
		.dm_rsp(dm_rsp),
		.port_in(port_in),
		.port_out(port_out),
		.port_strobe(port_strobe),
		.halted(halted)
	);

	tb_cpu_mem u_mem (
		.clk(clk),
		.reset(reset),
		.stall_en(stall_en),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dm_req(dm_req),
		.dm_rsp(dm_rsp)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program building
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [15:0] enc_rr(cpu_pkg::cpu_opcode_t op, int rd, int ra, int rb);
		return {op, 4'(rd), 4'(ra), 4'(rb)};
	endfunction

	function automatic logic [15:0] enc_ri(cpu_pkg::cpu_opcode_t op, int rd, logic [7:0] imm);
		return {op, 4'(rd), imm};
	endfunction

	function automatic logic [15:0] sext8(logic [7:0] b);
		return {{8{b[7]}}, b};
	endfunction

	// Builds a 16-bit constant by doubling the high byte eight times. Uses r13.
	task automatic emit_const(int r, logic [15:0] v);
		prog.push_back(enc_ri(cpu_pkg::OP_LDI, r, v[15:8]));
		repeat (8) prog.push_back(enc_rr(cpu_pkg::OP_ADD, r, r, r));
		prog.push_back(enc_ri(cpu_pkg::OP_LDI, 13, v[7:0]));
		prog.push_back(enc_rr(cpu_pkg::OP_OR, r, r, 13));
	endtask

	task automatic emit_out(int r);
		prog.push_back(enc_rr(cpu_pkg::OP_OUT, r, 0, 0));
	endtask

	task automatic start_test();
		prog.delete();
		exp_q.delete();
		test_errors = 0;
		for (int i = 0; i < 256; i++)
			u_mem.rom[i] = {cpu_pkg::OP_HALT, 12'h000};
		for (int i = 0; i < 64; i++)
			u_mem.dmem[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0001_0203);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Running and checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_program();
		int cycles;
		prog.push_back({cpu_pkg::OP_HALT, 12'h000});
		for (int i = 0; i < prog.size(); i++)
			u_mem.rom[i] = prog[i];
		outs.delete();
		@(negedge clk);
		reset = 1'b1;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		cycles = 0;
		while (!halted && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (port_strobe)
				outs.push_back(port_out);
		end
		if (!halted) begin
			$display("timeout: the core did not reach HALT within %0d cycles", RUN_LIMIT);
			errors++;
			test_errors++;
		end
		run_cycles = cycles;
	endtask

	task automatic flag_error(string msg);
		$display("error at %0t ns: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic compare_outputs();
		if (outs.size() != exp_q.size())
			flag_error($sformatf("%0d OUT values seen, %0d expected", outs.size(), exp_q.size()));
		for (int i = 0; i < outs.size() && i < exp_q.size(); i++)
			if (outs[i] !== exp_q[i])
				flag_error($sformatf("OUT %0d is %h, expected %h", i, outs[i], exp_q[i]));
	endtask

	task automatic end_test(string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic alu_test();
		logic [15:0] pa [4] = '{16'h1234, 16'hFFFF, 16'h7FFF, 16'h8000};
		logic [15:0] pb [4] = '{16'h0F0F, 16'h0001, 16'h0001, 16'h8000};
		start_test();
		for (int p = 0; p < 4; p++) begin
			emit_const(1, pa[p]);
			emit_const(2, pb[p]);
			for (int op = 0; op < 5; op++) begin
				prog.push_back(enc_rr(cpu_pkg::cpu_opcode_t'(op), 3, 1, 2));
				emit_out(3);
			end
			exp_q.push_back(pa[p] + pb[p]);
			exp_q.push_back(pa[p] - pb[p]);
			exp_q.push_back(pa[p] & pb[p]);
			exp_q.push_back(pa[p] | pb[p]);
			exp_q.push_back(pa[p] ^ pb[p]);
		end
		prog.push_back(enc_ri(cpu_pkg::OP_LDI, 4, 8'h85));
		emit_out(4);
		prog.push_back(enc_ri(cpu_pkg::OP_ADDI, 4, 8'hFD));
		emit_out(4);
		prog.push_back(enc_ri(cpu_pkg::OP_ADDI, 4, 8'h7F));
		emit_out(4);
		prog.push_back(enc_ri(cpu_pkg::OP_LDI, 0, 8'h55));	// Discarded by r0.
		emit_out(0);
		prog.push_back(enc_rr(cpu_pkg::OP_ADD, 5, 0, 4));
		emit_out(5);
		exp_q.push_back(16'h0085);
		exp_q.push_back(16'h0085 + sext8(8'hFD));
		exp_q.push_back(16'h0085 + sext8(8'hFD) + sext8(8'h7F));
		exp_q.push_back(16'h0000);
		exp_q.push_back(16'h0085 + sext8(8'hFD) + sext8(8'h7F));
		run_program();
		compare_outputs();
		// No memory phase here, so every instruction takes exactly four cycles.
		if (run_cycles != 4 * prog.size())
			flag_error($sformatf("HALT reached after %0d cycles, expected %0d",
				run_cycles, 4 * prog.size()));
		end_test("alu");
	endtask

	task automatic word_test(string name);
		start_test();
		prog.push_back(enc_ri(cpu_pkg::OP_LDI, 1, 8'h10));
		prog.push_back(enc_ri(cpu_pkg::OP_LDI, 2, 8'h12));
		prog.push_back(enc_ri(cpu_pkg::OP_LDI, 9, 8'h13));	// Bit 0 must be ignored.
		emit_const(3, 16'hBEEF);
		emit_const(4, 16'h1357);
		prog.push_back(enc_rr(cpu_pkg::OP_ST, 3, 1, 0));
		prog.push_back(enc_rr(cpu_pkg::OP_ST, 4, 2, 0));
		prog.push_back(enc_rr(cpu_pkg::OP_LD, 5, 1, 0));
		emit_out(5);
		prog.push_back(enc_rr(cpu_pkg::OP_LD, 6, 2, 0));
		emit_out(6);
		prog.push_back(enc_rr(cpu_pkg::OP_LD, 7, 9, 0));
		emit_out(7);
		exp_q = '{16'hBEEF, 16'h1357, 16'h1357};
		run_program();
		compare_outputs();
		if (u_mem.wstrb_log.size() != 2)
			flag_error($sformatf("%0d stores seen, 2 expected", u_mem.wstrb_log.size()));
		else if (u_mem.wstrb_log[0] !== 4'b0011 || u_mem.wstrb_log[1] !== 4'b1100)
			flag_error($sformatf("wstrb %b then %b, expected 0011 then 1100",
				u_mem.wstrb_log[0], u_mem.wstrb_log[1]));
		if (u_mem.dmem[4] !== 32'h1357_BEEF)
			flag_error($sformatf("memory word 4 is %h, expected 1357beef", u_mem.dmem[4]));
		end_test(name);
	endtask

	task automatic byte_test();
		logic [31:0] word;
		logic [7:0] b;
		start_test();
		word = 32'hFE01_807F;
		u_mem.dmem[8] = word;
		for (int k = 0; k < 4; k++) begin
			prog.push_back(enc_ri(cpu_pkg::OP_LDI, 1, 8'(8'h20 + k)));
			prog.push_back(enc_rr(cpu_pkg::OP_LDB, 2, 1, 0));
			emit_out(2);
			prog.push_back(enc_rr(cpu_pkg::OP_LDBS, 3, 1, 0));
			emit_out(3);
			b = word[8*k +: 8];
			exp_q.push_back({8'h00, b});
			exp_q.push_back({{8{b[7]}}, b});
		end
		run_program();
		compare_outputs();
		end_test("byte_load");
	endtask

	// Condition rule on the flags that SUB a, b leaves.
	function automatic logic movc_taken(int cond, logic [15:0] a, logic [15:0] b);
		logic [15:0] diff;
		diff = a - b;
		case (cond)
			0: return 1'b1;
			1: return diff == 16'h0000;
			2: return diff != 16'h0000;
			3: return a < b;	// Borrow.
			4: return diff[15];
			default: return 1'b0;
		endcase
	endfunction

	task automatic movc_test();
		logic [15:0] sa [4] = '{16'h0005, 16'h0009, 16'h0003, 16'hFFFF};
		logic [15:0] sb [4] = '{16'h0005, 16'h0004, 16'h0008, 16'h0001};
		start_test();
		for (int s = 0; s < 4; s++) begin
			emit_const(1, sa[s]);
			emit_const(2, sb[s]);
			prog.push_back(enc_rr(cpu_pkg::OP_SUB, 3, 1, 2));
			prog.push_back(enc_ri(cpu_pkg::OP_LDI, 7, 8'h5A));	// LDI leaves the flags.
			for (int c = 0; c < 6; c++) begin
				prog.push_back(enc_ri(cpu_pkg::OP_LDI, 8, 8'h11));
				prog.push_back(enc_rr(cpu_pkg::OP_MOVC, 8, 7, c));
				emit_out(8);
				exp_q.push_back(movc_taken(c, sa[s], sb[s]) ? 16'h005A : 16'h0011);
			end
		end
		run_program();
		compare_outputs();
		end_test("movc");
	endtask

	task automatic branch_test();
		int br_pc;
		start_test();
		port_in = 16'hC0DE;
		prog.push_back(enc_ri(cpu_pkg::OP_LDI, 1, 8'h33));
		br_pc = prog.size();
		prog.push_back(enc_ri(cpu_pkg::OP_BR, 1, 8'h01));	// Link, skip one.
		emit_out(1);
		emit_out(15);
		prog.push_back(enc_rr(cpu_pkg::OP_IN, 2, 0, 0));
		emit_out(2);
		prog.push_back(enc_ri(cpu_pkg::OP_BR, 0, 8'h01));	// No link this time.
		emit_out(1);
		emit_out(15);
		exp_q.push_back(16'(br_pc + 1));
		exp_q.push_back(16'hC0DE);
		exp_q.push_back(16'(br_pc + 1));
		run_program();
		compare_outputs();
		end_test("branch_link_in");
	endtask

	task automatic stall_halt_test();
		stall_en = 1'b1;
		word_test("backpressure");
		stall_en = 1'b0;
		test_errors = 0;
		for (int i = 0; i < 40; i++) begin
			@(negedge clk);
			if (!halted)
				flag_error("halted dropped after HALT");
			if (port_strobe)
				flag_error("port_strobe pulsed after HALT");
		end
		end_test("halt_hold");
	endtask

	initial begin
		reset = 1'b1;
		stall_en = 1'b0;
		port_in = 16'h0000;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		run_cycles = 0;
		alu_test();
		word_test("word_store_load");
		byte_test();
		movc_test();
		branch_test();
		stall_halt_test();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verilog/cpu_top.sv
/*
 * Core top level: sequencer, register file, ALU, writeback select
 * and load/store unit.
 */

`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_top (
	input logic clk,
	input logic reset,
	output logic [`CPU_PC_BITS-1:0] imem_addr,
	input logic [15:0] imem_data,
	output cpu_pkg::axil_req_t dm_req,
	input cpu_pkg::axil_rsp_t dm_rsp,
	input logic [`CPU_DATA_BITS-1:0] port_in,
	output logic [`CPU_DATA_BITS-1:0] port_out,
	output logic port_strobe,
	output logic halted
);

	cpu_pkg::cpu_instr_u instr;
	cpu_pkg::cpu_flags_t flags;
	cpu_pkg::cpu_opcode_t opcode;

	logic [`CPU_PC_BITS-1:0] pc_next;
	logic exec_en;
	logic mem_start;
	logic mem_done;
	logic wb_en;

	logic [`CPU_REG_SEL_BITS-1:0] rd_sel_a;
	logic [`CPU_REG_SEL_BITS-1:0] rd_sel_b;
	logic [`CPU_DATA_BITS-1:0] rd_data_a;
	logic [`CPU_DATA_BITS-1:0] rd_data_b;
	logic [`CPU_REG_SEL_BITS-1:0] wr_sel;
	logic [`CPU_DATA_BITS-1:0] wr_data;

	logic [`CPU_DATA_BITS-1:0] alu_result;
	logic [`CPU_DATA_BITS-1:0] mem_data;
	logic [1:0] mem_byte_sel;

	assign opcode = instr.rr.opcode;

	// ADDI and OUT take their operand from rd; ST stores rd.
	assign rd_sel_a = ((opcode == cpu_pkg::OP_ADDI) || (opcode == cpu_pkg::OP_OUT)) ?
		instr.rr.rd : instr.rr.ra;
	assign rd_sel_b = (opcode == cpu_pkg::OP_ST) ? instr.rr.rd : instr.rr.rb;

	assign port_out = rd_data_a;	// Qualified by port_strobe.

	cpu_control u_control (
		.clk(clk),
		.reset(reset),
		.instr_data(imem_data),
		.mem_done(mem_done),
		.fetch_addr(imem_addr),
		.instr(instr),
		.pc_next(pc_next),
		.exec_en(exec_en),
		.mem_start(mem_start),
		.wb_en(wb_en),
		.port_strobe(port_strobe),
		.halted(halted)
	);

	cpu_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.rd_sel_a(rd_sel_a),
		.rd_sel_b(rd_sel_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.wr_en(wb_en),
		.wr_sel(wr_sel),
		.wr_data(wr_data)
	);

	cpu_alu u_alu (
		.clk(clk),
		.reset(reset),
		.exec_en(exec_en),
		.instr(instr),
		.op_a(rd_data_a),
		.op_b(rd_data_b),
		.result(alu_result),
		.flags(flags)
	);

	cpu_writeback u_writeback (
		.instr(instr),
		.alu_result(alu_result),
		.mem_data(mem_data),
		.mem_byte_sel(mem_byte_sel),
		.port_in(port_in),
		.pc_link(pc_next),
		.flags(flags),
		.wr_sel(wr_sel),
		.wr_data(wr_data)
	);

	// The byte address is the ra value.
	cpu_lsu u_lsu (
		.clk(clk),
		.reset(reset),
		.mem_start(mem_start),
		.instr(instr),
		.addr(rd_data_a),
		.store_data(rd_data_b),
		.axi_req(dm_req),
		.axi_rsp(dm_rsp),
		.mem_data(mem_data),
		.mem_byte_sel(mem_byte_sel),
		.mem_done(mem_done)
	);

endmodule
